// File: design/bus_pkg.sv
// Wishbone bus package
// Bus widths, address types and the video memory map
package bus_pkg;

    localparam int WB_ADDR_WIDTH = 17;  // Bus address width
    localparam int DATA_WIDTH    = 8;   // Bus and CPU data width

    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;  // Wishbone byte address
    typedef logic [DATA_WIDTH-1:0]    wb_data_t;  // Wishbone / CPU data byte

    typedef logic [10:0] vram_ofs_t;  // Offset into video RAM window (2 KB)
    typedef logic [11:0] vrom_ofs_t;  // Offset into character ROM window (4 KB)

    // Memory map windows
    localparam wb_addr_t VRAM_BASE = 17'h08000;  // Video RAM
    localparam wb_addr_t VROM_BASE = 17'h10000;  // Character ROM

    // Bus address of a video RAM byte
    function automatic wb_addr_t vram_addr(input vram_ofs_t ofs);
        wb_addr_t addr;
        addr = VRAM_BASE + wb_addr_t'(ofs);
        return addr;
    endfunction

    // Bus address of a character ROM byte
    function automatic wb_addr_t vrom_addr(input vrom_ofs_t ofs);
        wb_addr_t addr;
        addr = VROM_BASE + wb_addr_t'(ofs);
        return addr;
    endfunction

endpackage

// File: design/crtc_pkg.sv
// CRTC package
// Register indices, counter types and the structs passed between video blocks
package crtc_pkg;

    typedef logic [4:0]  crtc_reg_idx_t;  // CRTC address register
    typedef logic [7:0]  char_cnt_t;      // Character count within a line
    typedef logic [6:0]  row_cnt_t;       // Character row count within a frame
    typedef logic [3:0]  sync_w_t;        // Sync pulse width
    typedef logic [13:0] ma_t;            // Refresh memory address
    typedef logic [4:0]  ra_t;            // Raster address (scanline in row)
    typedef logic [1:0]  fetch_stage_t;   // Transfer index within a fetch round

    // 6545 register indices
    localparam crtc_reg_idx_t R_HTOTAL     = 5'd0;
    localparam crtc_reg_idx_t R_HDISP      = 5'd1;
    localparam crtc_reg_idx_t R_HSYNC_POS  = 5'd2;
    localparam crtc_reg_idx_t R_SYNC_WIDTH = 5'd3;   // VS width high nibble, HS width low
    localparam crtc_reg_idx_t R_VTOTAL     = 5'd4;
    localparam crtc_reg_idx_t R_VDISP      = 5'd6;
    localparam crtc_reg_idx_t R_VSYNC_POS  = 5'd7;
    localparam crtc_reg_idx_t R_MAX_SCAN   = 5'd9;
    localparam crtc_reg_idx_t R_START_HI   = 5'd12;  // Bits 13:8 of start address
    localparam crtc_reg_idx_t R_START_LO   = 5'd13;

    // Fetch round order
    localparam fetch_stage_t FETCH_EVEN_RAM = 2'd0;
    localparam fetch_stage_t FETCH_EVEN_ROM = 2'd1;
    localparam fetch_stage_t FETCH_ODD_RAM  = 2'd2;
    localparam fetch_stage_t FETCH_ODD_ROM  = 2'd3;

    typedef struct packed {
        char_cnt_t htotal;       // Last character of a line
        char_cnt_t hdisp;        // Displayed characters per line
        char_cnt_t hsync_pos;    // HS start character
        sync_w_t   hsync_width;  // In character clocks
        sync_w_t   vsync_width;  // In scanlines
        row_cnt_t  vtotal;       // Last row of a frame
        row_cnt_t  vdisp;        // Displayed rows
        row_cnt_t  vsync_pos;    // VS start row
        ra_t       max_scan;     // Last scanline of a row
        ma_t       start_addr;   // Refresh address of first character
    } crtc_regs_t;

    typedef struct packed {
        logic de;  // Display enable
        ma_t  ma;
        ra_t  ra;
    } crtc_timing_t;

    typedef struct packed {
        logic [7:0] even_glyph;  // Glyph row of even column
        logic [7:0] odd_glyph;   // Glyph row of odd column
        logic       invert;      // TA12 of the pair
    } glyph_pair_t;

endpackage

// File: design/crtc_regs.sv
// CRTC register file
// CPU address register, programmed timing values and read-back mux
`timescale 1ns/1ps

module crtc_regs (
    input  logic                 wb_clock_i,
    input  logic                 arst_n_i,
    input  logic                 crtc_cs_i,       // Chip select from address decode
    input  logic                 crtc_we_i,       // 1 = CPU writes
    input  logic                 crtc_rs_i,       // 0 = address/status, 1 = data register
    input  logic                 wr_strobe_i,     // One-cycle CPU write strobe
    input  bus_pkg::wb_data_t    crtc_data_i,
    output bus_pkg::wb_data_t    crtc_data_o,
    output logic                 crtc_data_oe_o,  // CPU is reading
    output crtc_pkg::crtc_regs_t regs_o
);
    import bus_pkg::*;
    import crtc_pkg::*;

    crtc_reg_idx_t addr_q;   // Selected register
    crtc_regs_t    regs_q;
    wb_data_t      rd_data;
    logic          wr_en;

    assign wr_en = wr_strobe_i && crtc_cs_i && crtc_we_i;

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_q <= '0;
            regs_q <= '0;
        end else if (wr_en) begin
            if (!crtc_rs_i) begin
                addr_q <= crtc_data_i[4:0];  // Address register write
            end else begin
                case (addr_q)
                    R_HTOTAL:     regs_q.htotal            <= crtc_data_i;
                    R_HDISP:      regs_q.hdisp             <= crtc_data_i;
                    R_HSYNC_POS:  regs_q.hsync_pos         <= crtc_data_i;
                    R_SYNC_WIDTH: begin
                        regs_q.hsync_width <= crtc_data_i[3:0];
                        regs_q.vsync_width <= crtc_data_i[7:4];
                    end
                    R_VTOTAL:     regs_q.vtotal            <= crtc_data_i[6:0];
                    R_VDISP:      regs_q.vdisp             <= crtc_data_i[6:0];
                    R_VSYNC_POS:  regs_q.vsync_pos         <= crtc_data_i[6:0];
                    R_MAX_SCAN:   regs_q.max_scan          <= crtc_data_i[4:0];
                    R_START_HI:   regs_q.start_addr[13:8]  <= crtc_data_i[5:0];
                    R_START_LO:   regs_q.start_addr[7:0]   <= crtc_data_i;
                    default: ;                              // Unimplemented index
                endcase
            end
        end
    end

    // Read-back of addressed register, zero-extended
    always_comb begin
        rd_data = '0;
        case (addr_q)
            R_HTOTAL:     rd_data = regs_q.htotal;
            R_HDISP:      rd_data = regs_q.hdisp;
            R_HSYNC_POS:  rd_data = regs_q.hsync_pos;
            R_SYNC_WIDTH: rd_data = {regs_q.vsync_width, regs_q.hsync_width};
            R_VTOTAL:     rd_data = wb_data_t'(regs_q.vtotal);
            R_VDISP:      rd_data = wb_data_t'(regs_q.vdisp);
            R_VSYNC_POS:  rd_data = wb_data_t'(regs_q.vsync_pos);
            R_MAX_SCAN:   rd_data = wb_data_t'(regs_q.max_scan);
            R_START_HI:   rd_data = wb_data_t'(regs_q.start_addr[13:8]);
            R_START_LO:   rd_data = regs_q.start_addr[7:0];
            default:      rd_data = '0;
        endcase
    end

    assign crtc_data_o    = crtc_rs_i ? rd_data : '0;  // Status reads as zero
    assign crtc_data_oe_o = crtc_cs_i && !crtc_we_i;
    assign regs_o         = regs_q;

endmodule

// File: design/crtc_timing.sv
// CRTC timing generator
// Character, scanline and row counters producing sync, DE, MA and RA
`timescale 1ns/1ps

module crtc_timing (
    input  logic                   wb_clock_i,
    input  logic                   arst_n_i,
    input  logic                   cpu_reset_i,  // Synchronous counter reset
    input  logic                   cclk_en_i,    // Character clock enable
    input  crtc_pkg::crtc_regs_t   regs_i,
    output crtc_pkg::crtc_timing_t timing_o,
    output logic                   h_sync_o,
    output logic                   v_sync_o
);
    import crtc_pkg::*;

    char_cnt_t h_cnt, h_next;        // Character in line
    ra_t       scan_cnt, scan_next;  // Scanline in row
    row_cnt_t  row_cnt, row_next;    // Row in frame
    ma_t       row_ma, row_ma_next;  // Refresh address of first char in row
    sync_w_t   hs_left;              // HS enables remaining
    sync_w_t   vs_left;              // VS lines remaining
    logic      h_end;
    logic      scan_end;
    logic      frame_end;
    logic      h_start;
    logic      v_start;

    assign h_end     = (h_cnt == regs_i.htotal);
    assign scan_end  = (scan_cnt == regs_i.max_scan);
    assign frame_end = (row_cnt == regs_i.vtotal);

    // Next counter position on a character clock
    always_comb begin
        h_next      = h_end ? '0 : h_cnt + 1'b1;
        scan_next   = scan_cnt;
        row_next    = row_cnt;
        row_ma_next = row_ma;
        if (h_end) begin
            if (scan_end) begin
                scan_next = '0;
                if (frame_end) begin
                    row_next    = '0;
                    row_ma_next = regs_i.start_addr;  // Start address latched per frame
                end else begin
                    row_next    = row_cnt + 1'b1;
                    row_ma_next = row_ma + ma_t'(regs_i.hdisp);
                end
            end else begin
                scan_next = scan_cnt + 1'b1;
            end
        end
    end

    assign h_start = (h_next == regs_i.hsync_pos) && (regs_i.hsync_width != '0);
    // VS starts on the first scanline of the sync row
    assign v_start = h_end && scan_end && (row_next == regs_i.vsync_pos)
                     && (regs_i.vsync_width != '0);

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            h_cnt    <= '0;
            scan_cnt <= '0;
            row_cnt  <= '0;
            row_ma   <= '0;
            hs_left  <= '0;
            vs_left  <= '0;
            h_sync_o <= 1'b0;
            v_sync_o <= 1'b0;
            timing_o <= '0;
        end else if (cpu_reset_i) begin
            h_cnt    <= '0;
            scan_cnt <= '0;
            row_cnt  <= '0;
            row_ma   <= '0;
            hs_left  <= '0;
            vs_left  <= '0;
            h_sync_o <= 1'b0;
            v_sync_o <= 1'b0;
            timing_o <= '0;
        end else if (cclk_en_i) begin
            h_cnt    <= h_next;
            scan_cnt <= scan_next;
            row_cnt  <= row_next;
            row_ma   <= row_ma_next;

            // Outputs describe the position just entered
            timing_o.de <= (h_next < regs_i.hdisp) && (row_next < regs_i.vdisp);
            timing_o.ma <= row_ma_next + ma_t'(h_next);
            timing_o.ra <= scan_next;

            if (h_start) begin
                h_sync_o <= 1'b1;
                hs_left  <= regs_i.hsync_width - 1'b1;
            end else if (hs_left != '0) begin
                hs_left  <= hs_left - 1'b1;
            end else begin
                h_sync_o <= 1'b0;
            end

            if (v_start) begin
                v_sync_o <= 1'b1;
                vs_left  <= regs_i.vsync_width - 1'b1;
            end else if (h_end) begin         // Width counted in lines
                if (vs_left != '0) begin
                    vs_left <= vs_left - 1'b1;
                end else begin
                    v_sync_o <= 1'b0;
                end
            end
        end
    end

endmodule

// File: design/video_fetch.sv
// Video fetch engine
// Wishbone master reading screen codes and glyph rows for a column pair
`timescale 1ns/1ps

module video_fetch (
    input  logic                   wb_clock_i,
    input  logic                   arst_n_i,
    input  crtc_pkg::crtc_timing_t timing_i,
    input  logic                   col_80_mode_i,  // 1 = 80 columns
    input  logic                   graphic_i,      // Character set select
    output bus_pkg::wb_addr_t      wb_addr_o,
    output bus_pkg::wb_data_t      wb_data_o,
    input  bus_pkg::wb_data_t      wb_data_i,
    output logic                   wb_we_o,
    output logic                   wb_cycle_o,
    output logic                   wb_strobe_o,
    input  logic                   wb_stall_i,
    input  logic                   wb_ack_i,
    output crtc_pkg::glyph_pair_t  glyph_o,
    output logic                   glyph_valid_o
);
    import bus_pkg::*;
    import crtc_pkg::*;

    typedef enum logic {
        WB_IDLE,
        WB_AWAIT_ACK
    } fetch_state_t;

    fetch_state_t state;
    fetch_stage_t stage;
    wb_addr_t     req_addr;
    logic         req;          // Request issued this cycle
    logic         take;         // Ack accepted this cycle

    // Round context, sampled at the first request
    ma_t          ma_q;
    ra_t          ra_q;
    logic         graphic_q;
    wb_data_t     even_code_q;
    wb_data_t     even_glyph_q;
    wb_data_t     odd_code_q;

    assign req  = (state == WB_IDLE) && !wb_stall_i;
    assign take = (state == WB_AWAIT_ACK) && wb_ack_i;

    always_comb begin
        unique case (stage)
            FETCH_EVEN_RAM: req_addr = vram_addr(col_80_mode_i
                                ? {timing_i.ma[9:0], 1'b0}     // 80 column
                                : {1'b0, timing_i.ma[9:0]});   // 40 column
            FETCH_EVEN_ROM: req_addr = vrom_addr({ma_q[13], graphic_q,
                                                  even_code_q[6:0], ra_q[2:0]});
            FETCH_ODD_RAM:  req_addr = vram_addr({ma_q[9:0], 1'b1});
            FETCH_ODD_ROM:  req_addr = vrom_addr({ma_q[13], graphic_q,
                                                  odd_code_q[6:0], ra_q[2:0]});
        endcase
    end

    // Bus control
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state         <= WB_IDLE;
            stage         <= FETCH_EVEN_RAM;
            wb_cycle_o    <= 1'b0;
            wb_strobe_o   <= 1'b0;
            glyph_valid_o <= 1'b0;
        end else begin
            wb_strobe_o   <= 1'b0;   // Single-cycle strobe
            glyph_valid_o <= 1'b0;
            if (req) begin
                wb_cycle_o  <= 1'b1;
                wb_strobe_o <= 1'b1;
                state       <= WB_AWAIT_ACK;
            end else if (take) begin
                stage <= stage + 1'b1;  // Wraps to even RAM after odd ROM
                state <= WB_IDLE;
                if (stage == FETCH_ODD_ROM) begin
                    wb_cycle_o    <= 1'b0;  // Round complete
                    glyph_valid_o <= 1'b1;
                end
            end
        end
    end

    // Address and captured data
    always_ff @(posedge wb_clock_i) begin
        if (req) begin
            wb_addr_o <= req_addr;
            if (stage == FETCH_EVEN_RAM) begin
                ma_q      <= timing_i.ma;
                ra_q      <= timing_i.ra;
                graphic_q <= graphic_i;
            end
        end
        if (take) begin
            unique case (stage)
                FETCH_EVEN_RAM: even_code_q  <= wb_data_i;
                FETCH_EVEN_ROM: even_glyph_q <= wb_data_i;
                FETCH_ODD_RAM:  odd_code_q   <= wb_data_i;
                FETCH_ODD_ROM: begin
                    glyph_o.even_glyph <= even_glyph_q;
                    glyph_o.odd_glyph  <= wb_data_i;
                    glyph_o.invert     <= ma_q[12];  // TA12
                end
            endcase
        end
    end

    assign wb_we_o   = 1'b0;  // Read-only master
    assign wb_data_o = '0;

endmodule

// File: design/video_top.sv
// Video subsystem top
// CRTC register file and timing generator feeding the Wishbone fetch engine
`timescale 1ns/1ps

module video_top (
    input  logic                  wb_clock_i,
    input  logic                  arst_n_i,
    output bus_pkg::wb_addr_t     wb_addr_o,
    output bus_pkg::wb_data_t     wb_data_o,
    input  bus_pkg::wb_data_t     wb_data_i,
    output logic                  wb_we_o,
    output logic                  wb_cycle_o,
    output logic                  wb_strobe_o,
    input  logic                  wb_stall_i,
    input  logic                  wb_ack_i,
    input  logic                  cpu_reset_i,
    input  logic                  wr_strobe_i,
    input  logic                  cclk_en_i,
    input  logic                  crtc_cs_i,
    input  logic                  crtc_we_i,
    input  logic                  crtc_rs_i,
    input  bus_pkg::wb_data_t     crtc_data_i,
    output bus_pkg::wb_data_t     crtc_data_o,
    output logic                  crtc_data_oe_o,
    input  logic                  col_80_mode_i,
    input  logic                  graphic_i,
    output logic                  h_sync_o,
    output logic                  v_sync_o,
    output crtc_pkg::glyph_pair_t glyph_o,
    output logic                  glyph_valid_o
);
    import crtc_pkg::*;

    crtc_regs_t   regs;    // Programmed CRTC values
    crtc_timing_t timing;  // DE, MA, RA

    crtc_regs u_regs (
        .wb_clock_i     (wb_clock_i),
        .arst_n_i       (arst_n_i),
        .crtc_cs_i      (crtc_cs_i),
        .crtc_we_i      (crtc_we_i),
        .crtc_rs_i      (crtc_rs_i),
        .wr_strobe_i    (wr_strobe_i),
        .crtc_data_i    (crtc_data_i),
        .crtc_data_o    (crtc_data_o),
        .crtc_data_oe_o (crtc_data_oe_o),
        .regs_o         (regs)
    );

    crtc_timing u_timing (
        .wb_clock_i  (wb_clock_i),
        .arst_n_i    (arst_n_i),
        .cpu_reset_i (cpu_reset_i),
        .cclk_en_i   (cclk_en_i),
        .regs_i      (regs),
        .timing_o    (timing),
        .h_sync_o    (h_sync_o),
        .v_sync_o    (v_sync_o)
    );

    video_fetch u_fetch (
        .wb_clock_i    (wb_clock_i),
        .arst_n_i      (arst_n_i),
        .timing_i      (timing),
        .col_80_mode_i (col_80_mode_i),
        .graphic_i     (graphic_i),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .wb_data_i     (wb_data_i),
        .wb_we_o       (wb_we_o),
        .wb_cycle_o    (wb_cycle_o),
        .wb_strobe_o   (wb_strobe_o),
        .wb_stall_i    (wb_stall_i),
        .wb_ack_i      (wb_ack_i),
        .glyph_o       (glyph_o),
        .glyph_valid_o (glyph_valid_o)
    );

endmodule

// File: test/video_asserts.sv
// Video protocol checker
// Concurrent checks on the fetch Wishbone master and on the sync outputs
`timescale 1ns/1ps

module video_asserts (
    input logic              wb_clock_i,
    input logic              arst_n_i,
    input logic              wb_cycle_i,
    input logic              wb_strobe_i,
    input logic              wb_we_i,
    input logic              wb_ack_i,
    input bus_pkg::wb_addr_t wb_addr_i,
    input logic              glyph_valid_i,
    input logic              cclk_en_i,
    input logic              cpu_reset_i,
    input logic              h_sync_i,
    input logic              v_sync_i
);
    logic waiting;  // Request issued, ack not yet seen

    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            waiting <= 1'b0;
        end else if (wb_strobe_i) begin
            waiting <= 1'b1;
        end else if (wb_ack_i) begin
            waiting <= 1'b0;
        end
    end

    stb_needs_cyc: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        wb_strobe_i |-> wb_cycle_i) else $error("Strobe without cycle");
    no_stb_waiting: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        waiting |-> !wb_strobe_i) else $error("Strobe while waiting for ack");
    addr_stable: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        waiting |-> $stable(wb_addr_i)) else $error("Address changed while waiting");
    never_write: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        !wb_we_i) else $error("Write enable asserted");
    valid_pulse: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        glyph_valid_i |=> !glyph_valid_i) else $error("Glyph valid longer than one cycle");
    hs_on_cclk: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        $changed(h_sync_i) |-> ($past(cclk_en_i) || $past(cpu_reset_i)))
        else $error("HS changed without character clock");
    vs_on_cclk: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        $changed(v_sync_i) |-> ($past(cclk_en_i) || $past(cpu_reset_i)))
        else $error("VS changed without character clock");

endmodule

bind video_fetch video_asserts u_fetch_asserts (
    .wb_clock_i (wb_clock_i), .arst_n_i (arst_n_i), .wb_cycle_i (wb_cycle_o),
    .wb_strobe_i (wb_strobe_o), .wb_we_i (wb_we_o), .wb_ack_i (wb_ack_i),
    .wb_addr_i (wb_addr_o), .glyph_valid_i (glyph_valid_o), .cclk_en_i (1'b0),
    .cpu_reset_i (1'b0), .h_sync_i (1'b0), .v_sync_i (1'b0)
);

bind crtc_timing video_asserts u_timing_asserts (
    .wb_clock_i (wb_clock_i), .arst_n_i (arst_n_i), .wb_cycle_i (1'b0),
    .wb_strobe_i (1'b0), .wb_we_i (1'b0), .wb_ack_i (1'b0),
    .wb_addr_i ('0), .glyph_valid_i (1'b0), .cclk_en_i (cclk_en_i),
    .cpu_reset_i (cpu_reset_i), .h_sync_i (h_sync_o), .v_sync_i (v_sync_o)
);

// File: test/tb_video.sv
// Video subsystem testbench
// Directed tests of the CRTC and the fetch engine against a Wishbone memory model
`timescale 1ns/1ps

module tb_video;
    import bus_pkg::*;
    import crtc_pkg::*;

    localparam int HTOTAL = 9;       // 10 characters per line
    localparam int HDISP = 8;
    localparam int HSYNC_POS = 8;
    localparam int HSW = 2;
    localparam int VSW = 2;
    localparam int VTOTAL = 5;
    localparam int VDISP = 4;
    localparam int VSYNC_POS = 4;
    localparam int MAX_SCAN = 3;
    localparam int TIMEOUT_CYCLES = 20000;

    logic wb_clock_i, arst_n_i;
    wb_addr_t wb_addr_o;
    wb_data_t wb_data_o, wb_data_i, crtc_data_i, crtc_data_o;
    logic wb_we_o, wb_cycle_o, wb_strobe_o, wb_stall_i, wb_ack_i;
    logic cpu_reset_i, wr_strobe_i, cclk_en_i, crtc_cs_i, crtc_we_i, crtc_rs_i;
    logic crtc_data_oe_o, col_80_mode_i, graphic_i, h_sync_o, v_sync_o, glyph_valid_o;
    glyph_pair_t glyph_o;

    logic [31:0] lcg_state;
    int unsigned cycle_cnt;
    int          error_cnt;
    wb_addr_t    cur_addr[4], snap_addr[4], hold_addr;
    wb_data_t    cur_data[4], snap_data[4];
    logic [1:0]  req_idx, ack_idx;
    int          pend;  // Cycles left until ack

    video_top UUT (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("Mismatch in %s: expected %0h, actual %0h", test, exp, act);
            error_cnt++;
            stop_with_failure();
        end
    endtask

    initial begin
        wb_clock_i = 1'b0;
        forever #10 wb_clock_i = ~wb_clock_i;
    end

    always @(posedge wb_clock_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    // Character clock enable every fourth cycle
    always @(posedge wb_clock_i) begin
        #2;
        cclk_en_i = (cycle_cnt % 4 == 0);
    end

    // Wishbone slave with random stall and 1 to 3 cycle ack latency
    always @(posedge wb_clock_i) begin
        logic     got_stb;
        wb_addr_t addr;
        wb_data_t wdata;
        got_stb = wb_strobe_o;
        addr    = wb_addr_o;
        wdata   = wb_data_o;
        #2;
        wb_ack_i = 1'b0;
        if (!arst_n_i) begin
            pend    = 0;
            req_idx = '0;
            ack_idx = '0;
        end else begin
            if (pend != 0) begin
                pend--;
                if (pend == 0) begin
                    wb_ack_i           = 1'b1;
                    wb_data_i          = hold_addr[7:0] ^ 8'h5A;
                    cur_data[ack_idx]  = wb_data_i;
                    if (ack_idx == 2'd3) begin
                        snap_addr = cur_addr;
                        snap_data = cur_data;
                    end
                    ack_idx++;
                end
            end
            if (got_stb) begin
                check_value("wishbone write data", 0, 32'(wdata));  // Reads only
                hold_addr         = addr;
                cur_addr[req_idx] = addr;
                req_idx++;
                pend = 1 + int'(lcg_next() % 3);
            end
        end
        wb_stall_i = (lcg_next() % 4 == 0);
    end

    task automatic cpu_write(input logic rs, input wb_data_t data);
        crtc_cs_i   = 1'b1;
        crtc_we_i   = 1'b1;
        crtc_rs_i   = rs;
        crtc_data_i = data;
        wr_strobe_i = 1'b1;
        @(posedge wb_clock_i);
        #2;
        wr_strobe_i = 1'b0;
        crtc_cs_i   = 1'b0;
        crtc_we_i   = 1'b0;
    endtask

    task automatic write_reg(input crtc_reg_idx_t idx, input wb_data_t data);
        cpu_write(1'b0, wb_data_t'(idx));
        cpu_write(1'b1, data);
    endtask

    task automatic cpu_read(input crtc_reg_idx_t idx, input logic rs, output wb_data_t data);
        cpu_write(1'b0, wb_data_t'(idx));
        crtc_cs_i = 1'b1;
        crtc_rs_i = rs;
        @(posedge wb_clock_i);
        #1;
        data = crtc_data_o;
        check_value("read oe", 1, 32'(crtc_data_oe_o));
        #1;
        crtc_cs_i = 1'b0;
    endtask

    // Implemented bits of each register
    function automatic wb_data_t reg_mask(input crtc_reg_idx_t idx);
        case (idx)
            R_VTOTAL, R_VDISP, R_VSYNC_POS: return 8'h7F;
            R_MAX_SCAN:                     return 8'h1F;
            R_START_HI:                     return 8'h3F;
            default:                        return 8'hFF;
        endcase
    endfunction

    task automatic registers_rw();
        crtc_reg_idx_t idx_list[10];
        wb_data_t      rd;
        idx_list = '{R_HTOTAL, R_HDISP, R_HSYNC_POS, R_SYNC_WIDTH, R_VTOTAL,
                     R_VDISP, R_VSYNC_POS, R_MAX_SCAN, R_START_HI, R_START_LO};
        foreach (idx_list[i]) write_reg(idx_list[i], 8'hC3 ^ (8'(idx_list[i]) * 8'h11));
        foreach (idx_list[i]) begin
            cpu_read(idx_list[i], 1'b1, rd);
            check_value("register readback",
                        32'((8'hC3 ^ (8'(idx_list[i]) * 8'h11)) & reg_mask(idx_list[i])),
                        32'(rd));
        end
        cpu_read(R_HTOTAL, 1'b0, rd);
        check_value("status read", 0, 32'(rd));
        crtc_cs_i = 1'b0;
        crtc_we_i = 1'b0;
        #1 check_value("oe without cs", 0, 32'(crtc_data_oe_o));
        crtc_cs_i = 1'b1;
        crtc_we_i = 1'b1;
        #1 check_value("oe on write", 0, 32'(crtc_data_oe_o));
        crtc_cs_i = 1'b0;
        crtc_we_i = 1'b0;
    endtask

    task automatic program_crtc(input logic [13:0] start);
        write_reg(R_HTOTAL, HTOTAL);
        write_reg(R_HDISP, HDISP);
        write_reg(R_HSYNC_POS, HSYNC_POS);
        write_reg(R_SYNC_WIDTH, {4'(VSW), 4'(HSW)});
        write_reg(R_VTOTAL, VTOTAL);
        write_reg(R_VDISP, VDISP);
        write_reg(R_VSYNC_POS, VSYNC_POS);
        write_reg(R_MAX_SCAN, MAX_SCAN);
        write_reg(R_START_HI, {2'b00, start[13:8]});
        write_reg(R_START_LO, start[7:0]);
    endtask

    task automatic pulse_cpu_reset();
        cpu_reset_i = 1'b1;
        @(posedge wb_clock_i);
        #2;
        cpu_reset_i = 1'b0;
    endtask

    // Period and width of a sync output, counted in character enables
    task automatic check_sync(input string test, input logic vert,
                              input int period, input int width);
        int   en_cnt;
        int   rises;
        logic prev, cur;
        en_cnt = 0;
        rises  = 0;
        prev   = 1'b1;
        while (rises < 3) begin
            @(posedge wb_clock_i);
            #1;
            cur = vert ? v_sync_o : h_sync_o;
            if (cclk_en_i) en_cnt++;
            if (cur && !prev) begin
                if (rises > 0) check_value({test, " period"}, period, en_cnt);
                rises++;
                en_cnt = 0;
            end
            if (!cur && prev && rises > 0) check_value({test, " width"}, width, en_cnt);
            prev = cur;
        end
        #1;
    endtask

    task automatic wait_glyph();
        do begin
            @(posedge wb_clock_i);
            #1;
        end while (!glyph_valid_o);
        check_value("fetch cycle end", 0, 32'(wb_cycle_o));  // Cycle drops on fourth ack
        #1;
    endtask

    task automatic fetch_addresses(input logic mode80, input logic gfx, input int rounds);
        logic [10:0] ofs0;
        wb_addr_t    exp;
        col_80_mode_i = mode80;
        graphic_i     = gfx;
        wait_glyph();  // Round in flight may use the old mode
        repeat (rounds) begin
            wait_glyph();
            ofs0 = 11'(snap_addr[0] - VRAM_BASE);
            check_value("fetch ram window", 32'(VRAM_BASE >> 11), 32'(snap_addr[0] >> 11));
            if (mode80) begin
                check_value("fetch 80 even lsb", 0, 32'(ofs0[0]));
                exp = VRAM_BASE + {6'd0, ofs0[10:1], 1'b1};
            end else begin
                check_value("fetch 40 even msb", 0, 32'(ofs0[10]));
                exp = VRAM_BASE + {6'd0, ofs0[9:0], 1'b1};
            end
            check_value("fetch odd ram", 32'(exp), 32'(snap_addr[2]));
            check_value("fetch raster", 1, 32'(snap_addr[1][2:0] <= 3'(MAX_SCAN)));
            exp = VROM_BASE + {5'd0, 1'b0, gfx, snap_data[0][6:0], snap_addr[1][2:0]};
            check_value("fetch even rom", 32'(exp), 32'(snap_addr[1]));
            exp = VROM_BASE + {5'd0, 1'b0, gfx, snap_data[2][6:0], snap_addr[1][2:0]};
            check_value("fetch odd rom", 32'(exp), 32'(snap_addr[3]));
            check_value("fetch invert", 0, 32'(glyph_o.invert));  // Start address is zero
        end
    endtask

    task automatic glyph_output(input int rounds);
        program_crtc(14'h1000);
        @(posedge v_sync_o);
        @(posedge v_sync_o);  // Start address latched at frame end
        @(posedge wb_clock_i);
        #2;
        wait_glyph();
        repeat (rounds) begin
            wait_glyph();
            check_value("glyph even", 32'(snap_data[1]), 32'(glyph_o.even_glyph));
            check_value("glyph odd", 32'(snap_data[3]), 32'(glyph_o.odd_glyph));
            check_value("glyph invert", 1, 32'(glyph_o.invert));
        end
    endtask

    task automatic hsync_after_cpu_reset();
        int en_cnt;
        en_cnt = 0;
        pulse_cpu_reset();
        forever begin
            @(posedge wb_clock_i);
            #1;
            if (cclk_en_i) en_cnt++;
            if (h_sync_o) break;
        end
        #1;
        check_value("cpu reset hsync delay", HSYNC_POS, en_cnt);
    endtask

    initial begin
        lcg_state = 32'h3751_c55f;
        cycle_cnt = 0;
        error_cnt = 0;
        {arst_n_i, cpu_reset_i, wr_strobe_i, cclk_en_i} = '0;
        {crtc_cs_i, crtc_we_i, crtc_rs_i, col_80_mode_i, graphic_i} = '0;
        {wb_stall_i, wb_ack_i} = '0;
        crtc_data_i = '0;
        wb_data_i   = '0;
        repeat (5) @(posedge wb_clock_i);
        #2;
        arst_n_i = 1'b1;
        registers_rw();
        program_crtc(14'h0000);
        pulse_cpu_reset();
        check_sync("horizontal", 1'b0, HTOTAL + 1, HSW);
        check_sync("vertical", 1'b1, (VTOTAL + 1) * (MAX_SCAN + 1) * (HTOTAL + 1),
                   VSW * (HTOTAL + 1));
        fetch_addresses(1'b0, 1'b0, 8);
        fetch_addresses(1'b1, 1'b1, 8);
        glyph_output(8);
        hsync_after_cpu_reset();
        if (error_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/bus_pkg.sv
design/crtc_pkg.sv
design/crtc_regs.sv
design/crtc_timing.sv
design/video_fetch.sv
design/video_top.sv
test/video_asserts.sv
test/tb_video.sv

// File: run_sim.sh
#!/bin/bash
# Compile and run the video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_video \
    --Mdir obj_dir -o sim_video > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_video > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }
